// ==== common/eth_test_pkg.sv ====
/*
 * shared sizes, reset defaults, register map and FSM states
 * for the four-port Ethernet link test engine
 */
`default_nettype none

package eth_test_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    localparam int unsigned N_PORTS = 4;
    localparam int unsigned BYTE_W  = 8;
    localparam int unsigned SIZE_W  = 16;
    localparam int unsigned CNT_W   = 32;
    localparam int unsigned ADDR_W  = 4;

    // frame length limits and values after reset
    localparam int unsigned MIN_PKT_SIZE   = 2;
    localparam int unsigned DEF_PKT_SIZE   = 64;
    localparam int unsigned DEF_PAUSE_SIZE = 16;

    // control word bit that fires the counter clear
    localparam int unsigned CLR_BIT = 24;

    // register map with addresses 8..15 reading as zero
    typedef enum logic [ADDR_W-1:0] {
        REG_CTRL       = 4'd0,
        REG_PKT_SIZE   = 4'd1,
        REG_PAUSE_SIZE = 4'd2,
        REG_STATUS     = 4'd3,
        REG_CNTERR0    = 4'd4,
        REG_CNTERR1    = 4'd5,
        REG_CNTERR2    = 4'd6,
        REG_CNTERR3    = 4'd7
    } reg_addr_e;

    // generator and checker FSM states
    typedef enum logic [1:0] {GEN_IDLE, GEN_REQ, GEN_SEND, GEN_PAUSE} gen_state_e;
    typedef enum logic {CHK_IDLE, CHK_FRAME} chk_state_e;

endpackage

`default_nettype wire

// ==== design/eth_test_top.sv ====
/*
 * link test engine top, one generator and one checker per port
 * around the register block; per-port buses are flat, port x in slice x
 */
`timescale 1ns/1ps
`default_nettype none

module eth_test_top
    import eth_test_pkg::*;
(
    input  wire logic                      clk125M,
    input  wire logic                      rst_i,
    // register access
    input  wire logic                      wr_stb_i,
    input  wire logic                      rd_stb_i,
    input  wire reg_addr_e                 addr_i,
    input  wire logic [CNT_W-1:0]          wr_data_i,
    output logic      [CNT_W-1:0]          rd_data_o,
    // link state from the MAC
    input  wire logic [N_PORTS-1:0]        link_i,
    // transmit side
    output logic      [N_PORTS-1:0]        tx_rq_o,
    input  wire logic [N_PORTS-1:0]        tx_ack_i,
    output logic      [N_PORTS-1:0]        tx_valid_o,
    output logic      [N_PORTS-1:0]        tx_sof_o,
    output logic      [N_PORTS-1:0]        tx_eof_o,
    output logic      [N_PORTS*BYTE_W-1:0] tx_data_o,
    // receive side
    input  wire logic [N_PORTS-1:0]        rx_valid_i,
    input  wire logic [N_PORTS-1:0]        rx_sof_i,
    input  wire logic [N_PORTS-1:0]        rx_eof_i,
    input  wire logic [N_PORTS-1:0]        rx_err_i,
    input  wire logic [N_PORTS*BYTE_W-1:0] rx_data_i
);

    logic [N_PORTS-1:0]       start;
    logic [N_PORTS-1:0]       test_err;
    logic [N_PORTS*CNT_W-1:0] cnterr;
    logic                     clr;
    logic [SIZE_W-1:0]        pkt_size;
    logic [SIZE_W-1:0]        pause_size;

    test_regs u_regs (
        .clk125M     (clk125M),
        .rst_i       (rst_i),
        .wr_stb_i    (wr_stb_i),
        .rd_stb_i    (rd_stb_i),
        .addr_i      (addr_i),
        .wr_data_i   (wr_data_i),
        .rd_data_o   (rd_data_o),
        .link_i      (link_i),
        .test_err_i  (test_err),
        .cnterr_i    (cnterr),
        .start_o     (start),
        .clr_o       (clr),
        .pkt_size_o  (pkt_size),
        .pause_size_o(pause_size)
    );

    // ------------------------------------------------------------------------
    // per-port traffic pair
    // ------------------------------------------------------------------------
    for (genvar x = 0; x < N_PORTS; x++) begin : g_port
        pkt_gen u_gen (
            .clk125M     (clk125M),
            .rst_i       (rst_i),
            .start_i     (start[x]),
            .link_i      (link_i[x]),
            .pkt_size_i  (pkt_size),
            .pause_size_i(pause_size),
            .tx_rq_o     (tx_rq_o[x]),
            .tx_ack_i    (tx_ack_i[x]),
            .tx_valid_o  (tx_valid_o[x]),
            .tx_sof_o    (tx_sof_o[x]),
            .tx_eof_o    (tx_eof_o[x]),
            .tx_data_o   (tx_data_o[x*BYTE_W +: BYTE_W])
        );

        pkt_chk u_chk (
            .clk125M   (clk125M),
            .rst_i     (rst_i),
            .clr_i     (clr),
            .pkt_size_i(pkt_size),
            .rx_valid_i(rx_valid_i[x]),
            .rx_sof_i  (rx_sof_i[x]),
            .rx_eof_i  (rx_eof_i[x]),
            .rx_err_i  (rx_err_i[x]),
            .rx_data_i (rx_data_i[x*BYTE_W +: BYTE_W]),
            .cnterr_o  (cnterr[x*CNT_W +: CNT_W]),
            .test_err_o(test_err[x])
        );
    end

endmodule

`default_nettype wire

// ==== design/test_regs.sv ====
/*
 * control and status registers of the link test engine,
 * strobed writes take effect next cycle, reads return data one cycle later
 */
`timescale 1ns/1ps
`default_nettype none

module test_regs
    import eth_test_pkg::*;
(
    input  wire logic                     clk125M,
    input  wire logic                     rst_i,
    input  wire logic                     wr_stb_i,
    input  wire logic                     rd_stb_i,
    input  wire reg_addr_e                addr_i,
    input  wire logic [CNT_W-1:0]         wr_data_i,
    output logic      [CNT_W-1:0]         rd_data_o,
    input  wire logic [N_PORTS-1:0]       link_i,
    input  wire logic [N_PORTS-1:0]       test_err_i,
    input  wire logic [N_PORTS*CNT_W-1:0] cnterr_i,
    output logic      [N_PORTS-1:0]       start_o,
    output logic                          clr_o,
    output logic      [SIZE_W-1:0]        pkt_size_o,
    output logic      [SIZE_W-1:0]        pause_size_o
);

    logic [SIZE_W-1:0] wr_size;
    logic [CNT_W-1:0]  rd_mux;

    // size fields sit in the low half of the write word
    assign wr_size = wr_data_i[SIZE_W-1:0];

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            start_o      <= '0;
            clr_o        <= 1'b0;
            pkt_size_o   <= SIZE_W'(DEF_PKT_SIZE);
            pause_size_o <= SIZE_W'(DEF_PAUSE_SIZE);
        end else begin
            // clear is a single-cycle pulse
            clr_o <= 1'b0;
            if (wr_stb_i) begin
                case (addr_i)
                    REG_CTRL: begin
                        start_o <= wr_data_i[N_PORTS-1:0];
                        clr_o   <= wr_data_i[CLR_BIT];
                    end
                    REG_PKT_SIZE: begin
                        // too short a frame is raised to the minimum
                        if (wr_size < SIZE_W'(MIN_PKT_SIZE)) begin
                            pkt_size_o <= SIZE_W'(MIN_PKT_SIZE);
                        end else begin
                            pkt_size_o <= wr_size;
                        end
                    end
                    REG_PAUSE_SIZE: pause_size_o <= wr_size;
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    always_comb begin
        rd_mux = '0;
        case (addr_i)
            REG_CTRL:       rd_mux[N_PORTS-1:0] = start_o;
            REG_PKT_SIZE:   rd_mux[SIZE_W-1:0]  = pkt_size_o;
            REG_PAUSE_SIZE: rd_mux[SIZE_W-1:0]  = pause_size_o;
            // test_err above link
            REG_STATUS:     rd_mux[2*N_PORTS-1:0] = {test_err_i, link_i};
            REG_CNTERR0:    rd_mux = cnterr_i[0*CNT_W +: CNT_W];
            REG_CNTERR1:    rd_mux = cnterr_i[1*CNT_W +: CNT_W];
            REG_CNTERR2:    rd_mux = cnterr_i[2*CNT_W +: CNT_W];
            REG_CNTERR3:    rd_mux = cnterr_i[3*CNT_W +: CNT_W];
            default:        rd_mux = '0;
        endcase
    end

    // read data holds until the next strobe
    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            rd_data_o <= '0;
        end else if (rd_stb_i) begin
            rd_data_o <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/eth_test_pkg.sv
design/test_regs.sv
traffic/pkt_gen.sv
traffic/pkt_chk.sv
design/eth_test_top.sv
verif/tb_eth_test.sv

// ==== traffic/pkt_chk.sv ====
/*
 * per-port receive checker; every byte must equal the first byte plus
 * its index, bad frames are counted and latch a sticky error flag
 */
`timescale 1ns/1ps
`default_nettype none

module pkt_chk
    import eth_test_pkg::*;
(
    input  wire logic              clk125M,
    input  wire logic              rst_i,
    input  wire logic              clr_i,
    input  wire logic [SIZE_W-1:0] pkt_size_i,
    input  wire logic              rx_valid_i,
    input  wire logic              rx_sof_i,
    input  wire logic              rx_eof_i,
    input  wire logic              rx_err_i,
    input  wire logic [BYTE_W-1:0] rx_data_i,
    output logic      [CNT_W-1:0]  cnterr_o,
    output logic                   test_err_o
);

    chk_state_e        state_q;
    logic [BYTE_W-1:0] base_q;
    logic [SIZE_W-1:0] idx_q;
    logic              bad_q;
    logic              sof_v;
    logic              eof_v;
    logic              byte_ok;
    logic              bump;

    // markers only count on valid bytes
    assign sof_v   = rx_valid_i && rx_sof_i;
    assign eof_v   = rx_valid_i && rx_eof_i;
    assign byte_ok = (rx_data_i == base_q + idx_q[BYTE_W-1:0]);

    // ------------------------------------------------------------------------
    // bad frame end detection
    // ------------------------------------------------------------------------
    always_comb begin
        bump = 1'b0;
        case (state_q)
            CHK_IDLE: begin
                // one-byte frame, or eof with no frame open
                if (eof_v) begin
                    bump = sof_v ? (rx_err_i || pkt_size_i != SIZE_W'(1)) : 1'b1;
                end
            end
            CHK_FRAME: begin
                // sof inside a frame ends the current one as bad
                if (sof_v) begin
                    bump = 1'b1;
                end else if (eof_v) begin
                    bump = bad_q || rx_err_i || !byte_ok || ((idx_q + 1'b1) != pkt_size_i);
                end
            end
            default: bump = 1'b0;
        endcase
    end

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            state_q    <= CHK_IDLE;
            idx_q      <= '0;
            bad_q      <= 1'b0;
            cnterr_o   <= '0;
            test_err_o <= 1'b0;
        end else begin
            case (state_q)
                CHK_IDLE: begin
                    if (sof_v && !eof_v) begin
                        state_q <= CHK_FRAME;
                        bad_q   <= rx_err_i;
                        idx_q   <= SIZE_W'(1);
                    end
                end
                CHK_FRAME: begin
                    if (eof_v) begin
                        state_q <= CHK_IDLE;
                    end else if (sof_v) begin
                        // resync on the new frame
                        bad_q <= rx_err_i;
                        idx_q <= SIZE_W'(1);
                    end else if (rx_valid_i) begin
                        bad_q <= bad_q || rx_err_i || !byte_ok;
                        idx_q <= idx_q + 1'b1;
                    end
                end
                default: state_q <= CHK_IDLE;
            endcase

            // clear wins over a count in the same cycle
            if (clr_i) begin
                cnterr_o   <= '0;
                test_err_o <= 1'b0;
            end else if (bump) begin
                if (cnterr_o != '1) begin
                    cnterr_o <= cnterr_o + 1'b1;
                end
                test_err_o <= 1'b1;
            end
        end
    end

    // first byte of each frame is the base
    always_ff @(posedge clk125M) begin
        if (sof_v) begin
            base_q <= rx_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== traffic/pkt_gen.sv ====
/*
 * per-port test frame generator that requests the MAC slot, sends
 * numbered bytes once confirmed and then pauses before the next request
 */
`timescale 1ns/1ps
`default_nettype none

module pkt_gen
    import eth_test_pkg::*;
(
    input  wire logic              clk125M,
    input  wire logic              rst_i,
    input  wire logic              start_i,
    input  wire logic              link_i,
    input  wire logic [SIZE_W-1:0] pkt_size_i,
    input  wire logic [SIZE_W-1:0] pause_size_i,
    output logic                   tx_rq_o,
    input  wire logic              tx_ack_i,
    output logic                   tx_valid_o,
    output logic                   tx_sof_o,
    output logic                   tx_eof_o,
    output logic      [BYTE_W-1:0] tx_data_o
);

    gen_state_e        state_q;
    logic [SIZE_W-1:0] remain_q;
    logic [SIZE_W-1:0] pause_q;
    logic [BYTE_W-1:0] seq_q;
    logic              frame_go;
    logic              rearm;

    // slot confirmed so the first byte goes out next cycle
    assign frame_go = (state_q == GEN_REQ) && tx_ack_i;
    assign rearm    = start_i && link_i;

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            state_q    <= GEN_IDLE;
            tx_rq_o    <= 1'b0;
            tx_valid_o <= 1'b0;
            tx_sof_o   <= 1'b0;
            tx_eof_o   <= 1'b0;
            remain_q   <= '0;
            pause_q    <= '0;
            seq_q      <= '0;
        end else begin
            case (state_q)
                GEN_IDLE: begin
                    if (rearm) begin
                        state_q <= GEN_REQ;
                        tx_rq_o <= 1'b1;
                    end
                end
                GEN_REQ: begin
                    // frame length is latched here and holds for the frame
                    if (tx_ack_i) begin
                        state_q    <= GEN_SEND;
                        tx_rq_o    <= 1'b0;
                        tx_valid_o <= 1'b1;
                        tx_sof_o   <= 1'b1;
                        tx_eof_o   <= (pkt_size_i == SIZE_W'(1));
                        remain_q   <= pkt_size_i - 1'b1;
                    end
                end
                GEN_SEND: begin
                    tx_sof_o <= 1'b0;
                    if (tx_eof_o) begin
                        tx_valid_o <= 1'b0;
                        tx_eof_o   <= 1'b0;
                        seq_q      <= seq_q + 1'b1;
                        // zero pause goes straight to the next request
                        if (pause_size_i != '0) begin
                            state_q <= GEN_PAUSE;
                            pause_q <= pause_size_i;
                        end else if (rearm) begin
                            state_q <= GEN_REQ;
                            tx_rq_o <= 1'b1;
                        end else begin
                            state_q <= GEN_IDLE;
                        end
                    end else begin
                        remain_q <= remain_q - 1'b1;
                        tx_eof_o <= (remain_q == SIZE_W'(1));
                    end
                end
                GEN_PAUSE: begin
                    // last idle cycle decides between next request and stop
                    if (pause_q == SIZE_W'(1)) begin
                        if (rearm) begin
                            state_q <= GEN_REQ;
                            tx_rq_o <= 1'b1;
                        end else begin
                            state_q <= GEN_IDLE;
                        end
                    end
                    pause_q <= pause_q - 1'b1;
                end
                default: state_q <= GEN_IDLE;
            endcase
        end
    end

    // byte k of a frame is seq + k
    always_ff @(posedge clk125M) begin
        if (frame_go) begin
            tx_data_o <= seq_q;
        end else if (tx_valid_o) begin
            tx_data_o <= tx_data_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_eth_test.sv ====
/*
 * testbench for the link test engine with a MAC loopback model, random ack
 * delay and frame corruption, a transmit monitor and register level tests
 */
`timescale 1ns/1ps
`default_nettype none

module tb_eth_test
    import eth_test_pkg::*;
();

    // frames per port in each test set the run limit
    localparam int N_ROUNDS     = 4;
    localparam int ROUND_FRAMES = 6;
    localparam int STOP_FRAMES  = 3;
    localparam int CLEAN_FRAMES = 20;
    localparam int ERR_FRAMES   = 8;
    localparam int CLR_FRAMES   = 4;
    localparam int MAX_PKT      = 40;
    localparam int MAX_PAUSE    = 20;
    localparam int TOTAL_FRAMES = N_ROUNDS * ROUND_FRAMES + STOP_FRAMES + CLEAN_FRAMES
                                + ERR_FRAMES + CLR_FRAMES;
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * (MAX_PKT + MAX_PAUSE + 8) + 2000;

    logic                      clk125M;
    logic                      rst;
    logic                      wr_stb;
    logic                      rd_stb;
    reg_addr_e                 addr;
    logic [CNT_W-1:0]          wr_data;
    logic [CNT_W-1:0]          rd_data;
    logic [N_PORTS-1:0]        link;
    logic [N_PORTS-1:0]        tx_rq;
    logic [N_PORTS-1:0]        tx_ack;
    logic [N_PORTS-1:0]        tx_valid;
    logic [N_PORTS-1:0]        tx_sof;
    logic [N_PORTS-1:0]        tx_eof;
    logic [N_PORTS*BYTE_W-1:0] tx_data;
    logic [N_PORTS-1:0]        rx_valid;
    logic [N_PORTS-1:0]        rx_sof;
    logic [N_PORTS-1:0]        rx_eof;
    logic [N_PORTS-1:0]        rx_err;
    logic [N_PORTS*BYTE_W-1:0] rx_data;

    // MAC model state
    logic [N_PORTS-1:0]        v_pipe [0:2];
    logic [N_PORTS-1:0]        sof_pipe [0:2];
    logic [N_PORTS-1:0]        eof_pipe [0:2];
    logic [N_PORTS-1:0]        err_pipe [0:2];
    logic [N_PORTS*BYTE_W-1:0] data_pipe [0:2];
    int                        ack_wait [N_PORTS];
    int                        corrupt_req [N_PORTS];
    int                        corrupt_done [N_PORTS];
    logic [N_PORTS-1:0]        corrupt_on;
    logic [N_PORTS-1:0]        corrupt_err;
    integer                    seed;

    // monitor state and expected register contents
    int                        idx [N_PORTS];
    int                        since_eof [N_PORTS];
    int                        frame_cnt [N_PORTS];
    logic [BYTE_W-1:0]         seq_exp [N_PORTS];
    logic [N_PORTS-1:0]        in_frame;
    logic [N_PORTS-1:0]        gap_on;
    logic [N_PORTS-1:0]        ack_prev;
    logic [N_PORTS-1:0]        rq_prev;
    logic [N_PORTS-1:0]        start_model;
    logic [N_PORTS-1:0]        start_dut;
    logic [N_PORTS-1:0]        start_prev;
    int                        cur_size;
    int                        cur_pause;
    int                        err_cnt;
    int                        tests_pass;
    int                        tests_fail;
    int                        cycles;

    eth_test_top u_dut (
        .clk125M   (clk125M),
        .rst_i     (rst),
        .wr_stb_i  (wr_stb),
        .rd_stb_i  (rd_stb),
        .addr_i    (addr),
        .wr_data_i (wr_data),
        .rd_data_o (rd_data),
        .link_i    (link),
        .tx_rq_o   (tx_rq),
        .tx_ack_i  (tx_ack),
        .tx_valid_o(tx_valid),
        .tx_sof_o  (tx_sof),
        .tx_eof_o  (tx_eof),
        .tx_data_o (tx_data),
        .rx_valid_i(rx_valid),
        .rx_sof_i  (rx_sof),
        .rx_eof_i  (rx_eof),
        .rx_err_i  (rx_err),
        .rx_data_i (rx_data)
    );

    always #4 clk125M = ~clk125M;

    // run limit
    always @(posedge clk125M) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [CNT_W-1:0] exp,
                                   input logic [CNT_W-1:0] act);
        $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        err_cnt++;
    endtask

    task automatic report_fail(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    // ------------------------------------------------------------------------
    // MAC model acks after 1..4 cycles and loops back four cycles later
    // ------------------------------------------------------------------------
    always @(posedge clk125M) begin
        logic [N_PORTS-1:0]        err_in;
        logic [N_PORTS*BYTE_W-1:0] flip;
        err_in = '0;
        flip   = '0;
        for (int p = 0; p < N_PORTS; p++) begin
            if (tx_ack[p]) begin
                tx_ack[p] <= 1'b0;
                ack_wait[p] = 0;
            end else if (tx_rq[p]) begin
                if (ack_wait[p] == 0) begin
                    ack_wait[p] = 1 + ($unsigned($random(seed)) % 4);
                end else if (ack_wait[p] == 1) begin
                    tx_ack[p] <= 1'b1;
                end else begin
                    ack_wait[p] = ack_wait[p] - 1;
                end
            end
            // pick the frame at its first byte
            if (tx_valid[p] && tx_sof[p]) begin
                corrupt_on[p] = (corrupt_done[p] < corrupt_req[p]);
                if (corrupt_on[p]) begin
                    corrupt_err[p]  = (corrupt_done[p] % 2) == 1;
                    corrupt_done[p] = corrupt_done[p] + 1;
                end
            end
            // err on first byte or bit flip on last byte
            if (tx_valid[p] && corrupt_on[p]) begin
                if (corrupt_err[p]) begin
                    err_in[p] = tx_sof[p];
                end else if (tx_eof[p]) begin
                    flip[p*BYTE_W] = 1'b1;
                end
            end
        end
        v_pipe[0]    <= tx_valid;
        sof_pipe[0]  <= tx_sof;
        eof_pipe[0]  <= tx_eof;
        err_pipe[0]  <= err_in;
        data_pipe[0] <= tx_data ^ flip;
        for (int s = 1; s < 3; s++) begin
            v_pipe[s]    <= v_pipe[s-1];
            sof_pipe[s]  <= sof_pipe[s-1];
            eof_pipe[s]  <= eof_pipe[s-1];
            err_pipe[s]  <= err_pipe[s-1];
            data_pipe[s] <= data_pipe[s-1];
        end
        rx_valid <= v_pipe[2];
        rx_sof   <= sof_pipe[2];
        rx_eof   <= eof_pipe[2];
        rx_err   <= err_pipe[2] & v_pipe[2];
        rx_data  <= data_pipe[2];
    end

    // ------------------------------------------------------------------------
    // transmit monitor
    // ------------------------------------------------------------------------
    always @(posedge clk125M) begin
        int                k;
        logic [BYTE_W-1:0] exp_byte;
        if (!rst) begin
            for (int p = 0; p < N_PORTS; p++) begin
                // first byte exactly one cycle after the ack
                assert ((tx_valid[p] && tx_sof[p]) == ack_prev[p]) else
                    report_fail($sformatf("port %0d frame start not right after the ack", p));
                if (tx_valid[p]) begin
                    k = tx_sof[p] ? 0 : idx[p];
                    exp_byte = seq_exp[p] + BYTE_W'(k);
                    assert (tx_sof[p] || in_frame[p]) else
                        report_fail($sformatf("port %0d data byte outside a frame", p));
                    assert (tx_data[p*BYTE_W +: BYTE_W] === exp_byte) else
                        report_mismatch($sformatf("tx_data_o[%0d]", p), exp_byte,
                                        tx_data[p*BYTE_W +: BYTE_W]);
                    assert (tx_eof[p] === (k == cur_size - 1)) else
                        report_mismatch($sformatf("tx_eof_o[%0d]", p), (k == cur_size - 1),
                                        tx_eof[p]);
                    if (tx_eof[p]) begin
                        in_frame[p]  <= 1'b0;
                        seq_exp[p]   <= seq_exp[p] + 1'b1;
                        frame_cnt[p] <= frame_cnt[p] + 1;
                        gap_on[p]    <= 1'b1;
                        since_eof[p] <= 0;
                    end else begin
                        in_frame[p] <= 1'b1;
                        idx[p]      <= k + 1;
                    end
                end else begin
                    assert (!in_frame[p]) else
                        report_fail($sformatf("port %0d tx_valid_o dropped inside a frame", p));
                end
                // new request only with start set and pause_size + 1 after eof
                if (tx_rq[p] && !rq_prev[p]) begin
                    assert (start_prev[p]) else
                        report_fail($sformatf("port %0d request raised with start clear", p));
                    if (gap_on[p]) begin
                        assert (since_eof[p] == cur_pause) else
                            report_mismatch($sformatf("eof to tx_rq_o gap[%0d]", p),
                                            cur_pause + 1, since_eof[p] + 1);
                        gap_on[p] <= 1'b0;
                    end
                end else if (gap_on[p]) begin
                    if (since_eof[p] >= cur_pause) begin
                        assert (!start_prev[p]) else
                            report_fail($sformatf("port %0d no request after the pause", p));
                        gap_on[p] <= 1'b0;
                    end else begin
                        since_eof[p] <= since_eof[p] + 1;
                    end
                end
            end
        end
        ack_prev   <= tx_ack;
        rq_prev    <= tx_rq;
        // mirror of the DUT start bits one cycle behind the write
        start_dut  <= start_model;
        start_prev <= start_dut;
    end

    // ------------------------------------------------------------------------
    // register access and traffic control
    // ------------------------------------------------------------------------
    task automatic write_reg(input reg_addr_e a, input logic [CNT_W-1:0] data);
        @(posedge clk125M);
        wr_stb  <= 1'b1;
        addr    <= a;
        wr_data <= data;
        if (a == REG_CTRL) begin
            start_model <= data[N_PORTS-1:0];
        end
        if (a == REG_PKT_SIZE) begin
            cur_size = (data[SIZE_W-1:0] < MIN_PKT_SIZE) ? MIN_PKT_SIZE : data[SIZE_W-1:0];
        end
        if (a == REG_PAUSE_SIZE) begin
            cur_pause = data[SIZE_W-1:0];
        end
        @(posedge clk125M);
        wr_stb <= 1'b0;
    endtask

    task automatic check_reg(input reg_addr_e a, input logic [CNT_W-1:0] exp);
        logic [CNT_W-1:0] got;
        @(posedge clk125M);
        rd_stb <= 1'b1;
        addr   <= a;
        @(posedge clk125M);
        rd_stb <= 1'b0;
        // data was latched on the last edge
        @(posedge clk125M);
        got = rd_data;
        assert (got === exp) else
            report_mismatch($sformatf("rd_data_o(%s)", a.name()), exp, got);
    endtask

    task automatic check_counters(input int exp [N_PORTS]);
        logic [N_PORTS-1:0] err_bits;
        err_bits = '0;
        for (int p = 0; p < N_PORTS; p++) begin
            check_reg(reg_addr_e'(REG_CNTERR0 + p), exp[p]);
            err_bits[p] = (exp[p] != 0);
        end
        check_reg(REG_STATUS, {err_bits, link});
    endtask

    // quiet for longer than a pause means every port is idle
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < cur_pause + 8) begin
            @(posedge clk125M);
            if (tx_rq == '0 && tx_valid == '0 && rx_valid == '0 && tx_ack == '0) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic run_frames(input logic [N_PORTS-1:0] ports, input int n);
        int   target [N_PORTS];
        logic done;
        for (int p = 0; p < N_PORTS; p++) begin
            target[p] = frame_cnt[p] + n;
        end
        write_reg(REG_CTRL, CNT_W'(ports));
        done = 1'b0;
        while (!done) begin
            @(posedge clk125M);
            done = 1'b1;
            for (int p = 0; p < N_PORTS; p++) begin
                if (ports[p] && frame_cnt[p] < target[p]) begin
                    done = 1'b0;
                end
            end
        end
        write_reg(REG_CTRL, '0);
        wait_quiet();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_pass++;
            $display("test %s: pass", name);
        end else begin
            tests_fail++;
            $display("test %s: fail with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        int e0;
        int n_stop;
        int zeros [N_PORTS];
        int bad_frames [N_PORTS];
        clk125M = 1'b0;
        rst     = 1'b1;
        wr_stb  = 1'b0;
        rd_stb  = 1'b0;
        addr    = REG_CTRL;
        wr_data = '0;
        link    = '1;
        tx_ack  = '0;
        {rx_valid, rx_sof, rx_eof, rx_err, rx_data} = '0;
        for (int s = 0; s < 3; s++) begin
            {v_pipe[s], sof_pipe[s], eof_pipe[s], err_pipe[s], data_pipe[s]} = '0;
        end
        for (int p = 0; p < N_PORTS; p++) begin
            {ack_wait[p], corrupt_req[p], corrupt_done[p], zeros[p]} = '0;
            {idx[p], since_eof[p], frame_cnt[p], seq_exp[p]} = '0;
        end
        {corrupt_on, corrupt_err, in_frame, gap_on, ack_prev, rq_prev} = '0;
        {start_model, start_dut, start_prev} = '0;
        cur_size   = DEF_PKT_SIZE;
        cur_pause  = DEF_PAUSE_SIZE;
        seed       = 32'h98971162;
        err_cnt    = 0;
        tests_pass = 0;
        tests_fail = 0;
        cycles     = 0;
        repeat (16) @(posedge clk125M);
        rst <= 1'b0;
        repeat (2) @(posedge clk125M);

        // reset defaults and size clamp
        e0 = err_cnt;
        assert (tx_rq === '0) else report_mismatch("tx_rq_o", 0, tx_rq);
        assert (tx_valid === '0) else report_mismatch("tx_valid_o", 0, tx_valid);
        assert (tx_sof === '0) else report_mismatch("tx_sof_o", 0, tx_sof);
        assert (tx_eof === '0) else report_mismatch("tx_eof_o", 0, tx_eof);
        assert (rd_data === '0) else report_mismatch("rd_data_o", 0, rd_data);
        check_reg(REG_CTRL, 0);
        check_reg(REG_PKT_SIZE, DEF_PKT_SIZE);
        check_reg(REG_PAUSE_SIZE, DEF_PAUSE_SIZE);
        check_counters(zeros);
        write_reg(REG_PKT_SIZE, 1);
        check_reg(REG_PKT_SIZE, MIN_PKT_SIZE);
        finish_test("reset defaults", e0);

        // random sizes on all ports with the monitor checking every byte
        e0 = err_cnt;
        for (int r = 0; r < N_ROUNDS; r++) begin
            write_reg(REG_PKT_SIZE, 2 + ($unsigned($random(seed)) % (MAX_PKT - 1)));
            write_reg(REG_PAUSE_SIZE, $unsigned($random(seed)) % (MAX_PAUSE + 1));
            run_frames('1, ROUND_FRAMES);
        end
        finish_test("transmit frame format", e0);

        // stop in the middle of a port 0 frame
        e0 = err_cnt;
        write_reg(REG_PKT_SIZE, MAX_PKT);
        write_reg(REG_PAUSE_SIZE, 12);
        write_reg(REG_CTRL, CNT_W'(4'hf));
        n_stop = frame_cnt[0] + 2;
        while (!(frame_cnt[0] >= n_stop && tx_valid[0] && !tx_eof[0])) begin
            @(posedge clk125M);
        end
        n_stop = frame_cnt[0];
        write_reg(REG_CTRL, '0);
        wait_quiet();
        repeat (50) @(posedge clk125M);
        assert (frame_cnt[0] == n_stop + 1) else
            report_mismatch("port 0 frames after stop", n_stop + 1, frame_cnt[0]);
        finish_test("pause and stop", e0);

        // clean loopback
        e0 = err_cnt;
        write_reg(REG_PKT_SIZE, 24);
        write_reg(REG_PAUSE_SIZE, 4);
        run_frames('1, CLEAN_FRAMES);
        check_counters(zeros);
        finish_test("clean loopback", e0);

        // corrupted frames alternate bit flip and rx_err
        e0 = err_cnt;
        bad_frames = '{3, 1, 0, 2};
        for (int p = 0; p < N_PORTS; p++) begin
            corrupt_req[p] = corrupt_done[p] + bad_frames[p];
        end
        run_frames('1, ERR_FRAMES);
        for (int p = 0; p < N_PORTS; p++) begin
            assert (corrupt_done[p] == corrupt_req[p]) else
                report_fail($sformatf("port %0d not all corrupted frames were sent", p));
        end
        check_counters(bad_frames);
        finish_test("error counting", e0);

        // clear with start bits in the same write
        e0 = err_cnt;
        write_reg(REG_CTRL, (CNT_W'(1) << CLR_BIT) | CNT_W'(4'b0101));
        check_counters(zeros);
        check_reg(REG_CTRL, 4'b0101);
        run_frames(4'b0101, CLR_FRAMES);
        check_counters(zeros);
        finish_test("clear command", e0);

        $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
